// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_top
FLIST      = list.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
src/core_pkg.sv
src/retire_if.sv
src/fetch_unit.sv
src/exec_unit.sv
src/commit_unit.sv
src/mini_core.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== sim/tb_checker.sv ====
//--------------------------------------------------------------------------
// Trace monitor, samples on the falling edge
// Rows are matched to retirements in order, the table must be straight-line
//--------------------------------------------------------------------------

module tb_checker
  import core_pkg::*;
#(
  parameter int rows = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [xlen-1:0]       imem_addr,
  input  logic                  trace_val,
  input  logic [xlen-1:0]       trace_pc,
  input  logic [reg_addr_w-1:0] trace_waddr,
  input  logic [xlen-1:0]       trace_wdata,
  input  logic                  trace_wen,
  input  logic                  trace_illegal,
  input  logic [xlen-1:0]       instret,
  input  alu_op_t               exp_op    [rows],
  input  logic [reg_addr_w-1:0] exp_waddr [rows],
  input  logic [xlen-1:0]       exp_wdata [rows],
  input  logic                  exp_wen   [rows],
  input  logic                  exp_ill   [rows],
  output logic                  done,
  output int                    checked,
  output int                    err_value,
  output int                    err_timing
);

  // Cycles since the first fetch out of reset
  logic [31:0] cyc;
  logic        first_seen;

  task automatic compare_field(input int row, input string what,
                               input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      err_value++;
      $display("ERROR %0t: row %0d (%s) %s is %h, expected %h",
               $time, row, exp_op[row].name(), what, got, want);
    end
  endtask

  task automatic check_row(input int row);
    compare_field(row, "pc", trace_pc, 32'(row * 4));
    compare_field(row, "waddr", 32'(trace_waddr), 32'(exp_waddr[row]));
    compare_field(row, "wen", 32'(trace_wen), 32'(exp_wen[row]));
    compare_field(row, "illegal", 32'(trace_illegal), 32'(exp_ill[row]));
    // Data only matters when a register is written
    if (exp_wen[row]) begin
      compare_field(row, "wdata", trace_wdata, exp_wdata[row]);
    end
    compare_field(row, "instret", instret, 32'(row + 1));
  endtask

  always @(negedge clk) begin
    // Reset still unknown counts as held
    if (rst_n !== 1'b1) begin
      cyc        = '0;
      first_seen = 1'b0;
      done       = 1'b0;
      checked    = 0;
      err_value  = 0;
      err_timing = 0;
    end else begin
      // Fetch address follows 0, 4, 8 from the first cycle out of reset
      if (imem_addr !== {cyc[29:0], 2'b00}) begin
        err_timing++;
        $display("ERROR %0t: fetch address %h, expected %h",
                 $time, imem_addr, {cyc[29:0], 2'b00});
      end
      if (trace_val) begin
        // Fixed latency of 3 cycles
        if (!first_seen) begin
          first_seen = 1'b1;
          if (cyc != 32'd3) begin
            err_timing++;
            $display("ERROR %0t: first retirement %0d cycles after first fetch, expected 3",
                     $time, cyc);
          end
        end
        if (checked < rows) begin
          check_row(checked);
          checked++;
          if (checked == rows) begin
            done = 1'b1;
          end
        end
      end
      cyc = cyc + 32'd1;
    end
  end

endmodule

// ==== sim/tb_top.sv ====
//--------------------------------------------------------------------------
// Testbench for mini_core, one straight-line program held in a table
// The memory model assumes the pc steps by 4 with no branches
// Registers are never reset, so the program writes each one before reading it
//--------------------------------------------------------------------------

module tb_top
  import core_pkg::*;
();

  localparam int num_rows     = 18;
  localparam int reset_cycles = 8;
  localparam int max_cycles   = num_rows + reset_cycles + 20;

  // RV32 major opcodes used to build the program
  localparam logic [6:0]  enc_op_reg = 7'h33;
  localparam logic [6:0]  enc_op_imm = 7'h13;
  localparam logic [6:0]  enc_op_lui = 7'h37;
  // ADDI x0,x0,0
  localparam logic [31:0] nop_word   = 32'h0000_0013;

  logic                  clk;
  logic                  rst_n;
  logic [xlen-1:0]       imem_addr;
  logic [xlen-1:0]       imem_data;
  logic                  trace_val;
  logic [xlen-1:0]       trace_pc;
  logic [reg_addr_w-1:0] trace_waddr;
  logic [xlen-1:0]       trace_wdata;
  logic                  trace_wen;
  logic                  trace_illegal;
  logic [xlen-1:0]       instret;

  // Program table, one instruction and its expected retirement per row
  logic [31:0]           tbl_inst  [num_rows];
  alu_op_t               exp_op    [num_rows];
  logic [reg_addr_w-1:0] exp_waddr [num_rows];
  logic [xlen-1:0]       exp_wdata [num_rows];
  logic                  exp_wen   [num_rows];
  logic                  exp_ill   [num_rows];

  // Instruction memory, only as deep as the program
  logic [31:0] imem [num_rows];
  int          rows_added;
  int          cycles;

  logic chk_done;
  int   chk_checked;
  int   err_value;
  int   err_timing;

  //------------------------------------------------------------------------
  // Encoders and table helpers
  //------------------------------------------------------------------------

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), enc_op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {imm, 5'(rs1), f3, 5'(rd), enc_op_imm};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd);
    return {imm, 5'(rd), enc_op_lui};
  endfunction

  task automatic add_row(input logic [31:0] inst, input alu_op_t op, input int waddr,
                         input logic [31:0] wdata, input int wen, input int ill);
    tbl_inst[rows_added]  = inst;
    exp_op[rows_added]    = op;
    exp_waddr[rows_added] = 5'(waddr);
    exp_wdata[rows_added] = wdata;
    exp_wen[rows_added]   = (wen != 0);
    exp_ill[rows_added]   = (ill != 0);
    rows_added++;
  endtask

  // Past the program the memory reads as NOPs
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [29:0] idx;
    idx = addr[31:2];
    if (idx < 30'(num_rows)) begin
      return imem[idx];
    end
    return nop_word;
  endfunction

  //------------------------------------------------------------------------
  // Clock, DUT and checker
  //------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  mini_core u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .trace_val     (trace_val),
    .trace_pc      (trace_pc),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata),
    .trace_wen     (trace_wen),
    .trace_illegal (trace_illegal),
    .instret       (instret)
  );

  tb_checker #(.rows(num_rows)) u_checker (
    .clk (clk), .rst_n (rst_n), .imem_addr (imem_addr),
    .trace_val (trace_val), .trace_pc (trace_pc), .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata), .trace_wen (trace_wen),
    .trace_illegal (trace_illegal), .instret (instret),
    .exp_op (exp_op), .exp_waddr (exp_waddr), .exp_wdata (exp_wdata),
    .exp_wen (exp_wen), .exp_ill (exp_ill),
    .done (chk_done), .checked (chk_checked),
    .err_value (err_value), .err_timing (err_timing)
  );

  // The pc moves to addr + 4 on this edge, so serve that word now
  always @(posedge clk) begin
    if (rst_n) begin
      imem_data <= fetch_word(imem_addr + 32'd4);
    end else begin
      imem_data <= fetch_word(32'd0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  //------------------------------------------------------------------------
  // Program and run control
  //------------------------------------------------------------------------

  initial begin
    rst_n      = 1'b0;
    cycles     = 0;
    rows_added = 0;
    // ALU results, negative immediates and both bypass paths
    add_row(enc_i(12'h005, 0, 3'd0, 1), op_add, 1, 32'h0000_0005, 1, 0);
    add_row(enc_i(12'hffd, 0, 3'd0, 2), op_add, 2, 32'hffff_fffd, 1, 0);
    add_row(enc_r(7'h00, 2, 1, 3'd0, 3), op_add, 3, 32'h0000_0002, 1, 0);
    add_row(enc_r(7'h20, 1, 3, 3'd0, 4), op_sub, 4, 32'hffff_fffd, 1, 0);
    add_row(enc_r(7'h00, 1, 4, 3'd2, 5), op_slt, 5, 32'h0000_0001, 1, 0);
    add_row(enc_r(7'h00, 2, 1, 3'd4, 6), op_xor, 6, 32'hffff_fff8, 1, 0);
    add_row(enc_r(7'h00, 5, 6, 3'd6, 7), op_or, 7, 32'hffff_fff9, 1, 0);
    add_row(enc_r(7'h00, 1, 7, 3'd7, 8), op_and, 8, 32'h0000_0001, 1, 0);
    add_row(enc_i(12'hff0, 7, 3'd7, 9), op_and, 9, 32'hffff_fff0, 1, 0);
    add_row(enc_i(12'h7f0, 8, 3'd6, 10), op_or, 10, 32'h0000_07f1, 1, 0);
    add_row(enc_i(12'hfff, 10, 3'd4, 11), op_xor, 11, 32'hffff_f80e, 1, 0);
    // -2034 < -2048 is false
    add_row(enc_i(12'h800, 11, 3'd2, 12), op_slt, 12, 32'h0000_0000, 1, 0);
    // LUI, then a dropped write to x0 and a read of it
    add_row(enc_u(20'habcde, 13), op_lui_pass, 13, 32'habcd_e000, 1, 0);
    add_row(enc_u(20'h12345, 0), op_lui_pass, 0, 32'h1234_5000, 0, 0);
    add_row(enc_r(7'h00, 13, 0, 3'd0, 14), op_add, 14, 32'habcd_e000, 1, 0);
    // Custom-0 opcode aimed at x1, x1 must keep 5
    add_row(32'h0000_008b, op_illegal, 1, 32'h0000_0000, 0, 1);
    add_row(enc_i(12'h000, 1, 3'd0, 15), op_add, 15, 32'h0000_0005, 1, 0);
    add_row(enc_r(7'h00, 1, 1, 3'd0, 16), op_add, 16, 32'h0000_000a, 1, 0);

    for (int i = 0; i < num_rows; i++) begin
      imem[i] = tbl_inst[i];
    end
    imem_data = imem[0];

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    while (!chk_done && cycles < max_cycles) begin
      @(posedge clk);
    end

    if (!chk_done) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions retired",
               cycles, chk_checked, num_rows);
    end
    $display("Summary: %0d of %0d rows checked, %0d value errors, %0d timing errors",
             chk_checked, num_rows, err_value, err_timing);
    if (!chk_done || err_value != 0 || err_timing != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

// ==== src/commit_unit.sv ====
//--------------------------------------------------------------------------
// Commit stage, drives the trace port and the register write-back
// instret counts every retirement, illegal ones included
//--------------------------------------------------------------------------

module commit_unit
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  retire_if.commit              res,
  output logic                  trace_val,
  output logic [xlen-1:0]       trace_pc,
  output logic [reg_addr_w-1:0] trace_waddr,
  output logic [xlen-1:0]       trace_wdata,
  output logic                  trace_wen,
  output logic                  trace_illegal,
  output logic [xlen-1:0]       instret
);

  //------------------------------------------------------------------------
  // Trace register
  //------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_val     <= 1'b0;
      trace_wen     <= 1'b0;
      trace_illegal <= 1'b0;
      instret       <= '0;
    end else begin
      trace_val     <= res.val;
      trace_wen     <= res.wen;
      trace_illegal <= res.illegal;
      if (res.val) begin
        instret <= instret + 1'b1;
      end
    end
  end

  // Payload holds the last retirement between valid cycles
  always_ff @(posedge clk) begin
    if (res.val) begin
      trace_pc    <= res.pc;
      trace_waddr <= res.waddr;
      trace_wdata <= res.wdata;
    end
  end

  // Write-back taken straight from the trace register
  assign res.wb_en   = trace_wen;
  assign res.wb_addr = trace_waddr;
  assign res.wb_data = trace_wdata;

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------

  // Sequential retirement, each pc is the previous one plus 4
  // instret != 0 skips the first retirement after reset
  a_pc_in_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    (res.val && instret != '0) |=> (trace_pc == $past(trace_pc) + pc_step)
  ) else $error("commit_unit: out-of-order retirement at pc %h", trace_pc);

endmodule

// ==== src/core_pkg.sv ====
//--------------------------------------------------------------------------
// Shared constants and types for the RV32 mini core
// Only the ALU subset is encoded here: R-type, I-type ALU and LUI
// Any other opcode decodes to op_illegal
//--------------------------------------------------------------------------

package core_pkg;

  //------------------------------------------------------------------------
  // Widths and reset values
  //------------------------------------------------------------------------

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // First fetch address and sequential step
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen-1:0] pc_step  = 32'd4;

  //------------------------------------------------------------------------
  // Major opcodes
  //------------------------------------------------------------------------

  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  // funct3, shared by R-type and I-type forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7, base form and the SUB variant
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub  = 7'b0100000;

  //------------------------------------------------------------------------
  // Instruction word, two views of the same 32 bits
  //------------------------------------------------------------------------

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } inst_r_t;

  // LUI reuses this view, imm12/rs1/funct3 form imm[31:12]
  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

  //------------------------------------------------------------------------
  // Decoded ALU operation
  //------------------------------------------------------------------------

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_lui_pass,
    op_illegal
  } alu_op_t;

endpackage

// ==== src/exec_unit.sv ====
//--------------------------------------------------------------------------
// Execute stage, decode, register file and ALU in one cycle
// Operands bypass from the pending result and from write-back
// Unknown opcodes retire as illegal and never write a register
//--------------------------------------------------------------------------

module exec_unit
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            f_val,
  input  logic [xlen-1:0] f_pc,
  input  inst_t           f_inst,
  retire_if.exec          res
);

  // Architectural registers, x0 is never written
  logic [xlen-1:0] regs [num_regs];

  alu_op_t               alu_op;
  logic                  use_imm;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       rs1_val;
  logic [xlen-1:0]       rs2_val;
  logic [xlen-1:0]       op_b;
  logic [xlen-1:0]       alu_result;
  logic [reg_addr_w-1:0] rd;

  //------------------------------------------------------------------------
  // Decode
  //------------------------------------------------------------------------

  assign rd    = f_inst.i.rd;
  // Sign-extended I immediate
  assign imm_i = {{(xlen-12){f_inst.i.imm12[11]}}, f_inst.i.imm12};
  // LUI upper immediate, low 12 bits zero
  assign imm_u = {f_inst.i.imm12, f_inst.i.rs1, f_inst.i.funct3, 12'b0};

  always_comb begin
    alu_op  = op_illegal;
    use_imm = 1'b0;
    case (f_inst.r.opcode)
      op_reg: begin
        // R-type, funct7 must be base except for SUB
        case (f_inst.r.funct3)
          f3_add_sub: begin
            if (f_inst.r.funct7 == funct7_sub) begin
              alu_op = op_sub;
            end else if (f_inst.r.funct7 == funct7_base) begin
              alu_op = op_add;
            end
          end
          f3_slt: if (f_inst.r.funct7 == funct7_base) alu_op = op_slt;
          f3_xor: if (f_inst.r.funct7 == funct7_base) alu_op = op_xor;
          f3_or:  if (f_inst.r.funct7 == funct7_base) alu_op = op_or;
          f3_and: if (f_inst.r.funct7 == funct7_base) alu_op = op_and;
          default: alu_op = op_illegal;
        endcase
      end
      op_imm: begin
        use_imm = 1'b1;
        case (f_inst.i.funct3)
          f3_add_sub: alu_op = op_add;
          f3_slt:     alu_op = op_slt;
          f3_xor:     alu_op = op_xor;
          f3_or:      alu_op = op_or;
          f3_and:     alu_op = op_and;
          // Shifts are outside the subset
          default:    alu_op = op_illegal;
        endcase
      end
      op_lui: begin
        alu_op  = op_lui_pass;
        use_imm = 1'b1;
      end
      default: alu_op = op_illegal;
    endcase
  end

  //------------------------------------------------------------------------
  // Register read with bypass
  //------------------------------------------------------------------------

  // Newest value wins: pending result, then write-back, then the array
  function automatic logic [xlen-1:0] read_operand(input logic [reg_addr_w-1:0] idx);
    logic [xlen-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (res.wen && res.waddr == idx) begin
      value = res.wdata;
    end else if (res.wb_en && res.wb_addr == idx) begin
      value = res.wb_data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  assign rs1_val = read_operand(f_inst.r.rs1);
  assign rs2_val = read_operand(f_inst.r.rs2);

  // LUI takes the upper immediate, other I-types the signed one
  assign op_b = !use_imm ? rs2_val :
                (alu_op == op_lui_pass) ? imm_u : imm_i;

  // Write port driven by commit
  always_ff @(posedge clk) begin
    if (res.wb_en && res.wb_addr != '0) begin
      regs[res.wb_addr] <= res.wb_data;
    end
  end

  //------------------------------------------------------------------------
  // ALU
  //------------------------------------------------------------------------

  always_comb begin
    case (alu_op)
      op_add:      alu_result = rs1_val + op_b;
      op_sub:      alu_result = rs1_val - op_b;
      op_and:      alu_result = rs1_val & op_b;
      op_or:       alu_result = rs1_val | op_b;
      op_xor:      alu_result = rs1_val ^ op_b;
      op_slt:      alu_result = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      op_lui_pass: alu_result = op_b;
      default:     alu_result = '0;
    endcase
  end

  //------------------------------------------------------------------------
  // Result register
  //------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res.val     <= 1'b0;
      res.wen     <= 1'b0;
      res.illegal <= 1'b0;
    end else begin
      res.val     <= f_val;
      // No write for x0 or an illegal word
      res.wen     <= f_val && (alu_op != op_illegal) && (rd != '0);
      res.illegal <= f_val && (alu_op == op_illegal);
    end
  end

  always_ff @(posedge clk) begin
    res.pc    <= f_pc;
    res.waddr <= rd;
    res.wdata <= alu_result;
  end

  // An illegal retirement must not reach the register file
  a_illegal_no_wb: assert property (
    @(posedge clk) disable iff (!rst_n)
    res.illegal |=> !res.wb_en
  ) else $error("exec_unit: write-back to x%0d after illegal retirement", res.wb_addr);

endmodule

// ==== src/fetch_unit.sv ====
//--------------------------------------------------------------------------
// Fetch stage, pc steps by 4 every cycle, no branches and no stalls
// Instruction memory must answer in the same cycle as the address
//--------------------------------------------------------------------------

module fetch_unit
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  inst_t           imem_data,
  output logic [xlen-1:0] imem_addr,
  output logic            f_val,
  output logic [xlen-1:0] f_pc,
  output inst_t           f_inst
);

  // Address of the word being fetched this cycle
  logic [xlen-1:0] pc;

  assign imem_addr = pc;

  //------------------------------------------------------------------------
  // Program counter and valid
  //------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= reset_pc;
      f_val <= 1'b0;
    end else begin
      // Straight-line code only
      pc    <= pc + pc_step;
      f_val <= 1'b1;
    end
  end

  // Fetched word paired with its pc
  always_ff @(posedge clk) begin
    f_pc   <= pc;
    f_inst <= imem_data;
  end

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------

  // Fetch address stays on a word boundary
  a_imem_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    imem_addr[1:0] == 2'b00
  ) else $error("fetch_unit: misaligned fetch address %h", imem_addr);

endmodule

// ==== src/mini_core.sv ====
//--------------------------------------------------------------------------
// RV32 ALU-subset core, three stages, fixed latency of 3 cycles
// imem_data must be returned in the cycle imem_addr is driven
//--------------------------------------------------------------------------

module mini_core
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction port
  output logic [xlen-1:0]       imem_addr,
  input  logic [xlen-1:0]       imem_data,
  // Retirement trace
  output logic                  trace_val,
  output logic [xlen-1:0]       trace_pc,
  output logic [reg_addr_w-1:0] trace_waddr,
  output logic [xlen-1:0]       trace_wdata,
  output logic                  trace_wen,
  output logic                  trace_illegal,
  output logic [xlen-1:0]       instret
);

  // Fetch to execute
  logic            f_val;
  logic [xlen-1:0] f_pc;
  inst_t           f_inst;

  // Execute to commit and back
  retire_if u_res ();

  fetch_unit u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .f_val     (f_val),
    .f_pc      (f_pc),
    .f_inst    (f_inst)
  );

  exec_unit u_exec (
    .clk    (clk),
    .rst_n  (rst_n),
    .f_val  (f_val),
    .f_pc   (f_pc),
    .f_inst (f_inst),
    .res    (u_res.exec)
  );

  commit_unit u_commit (
    .clk           (clk),
    .rst_n         (rst_n),
    .res           (u_res.commit),
    .trace_val     (trace_val),
    .trace_pc      (trace_pc),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata),
    .trace_wen     (trace_wen),
    .trace_illegal (trace_illegal),
    .instret       (instret)
  );

endmodule

// ==== src/retire_if.sv ====
//--------------------------------------------------------------------------
// Link between execute and commit
// Result group flows forward, write-back group flows back one cycle later
//--------------------------------------------------------------------------

interface retire_if
  import core_pkg::*;
();

  // Result of the instruction leaving execute
  logic                  val;
  logic [xlen-1:0]       pc;
  logic [reg_addr_w-1:0] waddr;
  logic [xlen-1:0]       wdata;
  logic                  wen;
  logic                  illegal;

  // Register file write from the commit stage
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;

  modport exec (
    output val, pc, waddr, wdata, wen, illegal,
    input  wb_en, wb_addr, wb_data
  );

  modport commit (
    input  val, pc, waddr, wdata, wen, illegal,
    output wb_en, wb_addr, wb_data
  );

endinterface
